//--- verilog/gfx_mode_pkg.sv
package gfx_mode_pkg;

  // framebuffer geometry, one word per pixel
  localparam int fb_width  = 320;
  localparam int fb_height = 240;

  // coordinate widths follow from the size
  localparam int fb_x_bits = $clog2(fb_width);
  localparam int fb_y_bits = $clog2(fb_height);

  localparam int color_bits = 8;

  // word address of a pixel is y * fb_width + x
  localparam int fb_addr_bits = $clog2(fb_width * fb_height);

  // queue depths between the stages
  localparam int cmd_fifo_depth = 4;
  localparam int pix_fifo_depth = 8;

  // one queued line, endpoints as written by the host
  typedef struct packed {
    logic [fb_x_bits-1:0]  x0;
    logic [fb_y_bits-1:0]  y0;
    logic [fb_x_bits-1:0]  x1;
    logic [fb_y_bits-1:0]  y1;
    logic [color_bits-1:0] color;
  } line_cmd_t;

  // one rasterized pixel on its way to memory
  typedef struct packed {
    logic [fb_x_bits-1:0]  x;
    logic [fb_y_bits-1:0]  y;
    logic [color_bits-1:0] color;
  } pixel_t;

endpackage

//--- verilog/gfx_bus_pkg.sv
package gfx_bus_pkg;

  // host port widths
  localparam int wb_data_bits = 32;
  localparam int wb_addr_bits = 4;

  // register offsets, in words
  // x0 in the low half, y0 in the high half
  localparam logic [wb_addr_bits-1:0] reg_p0 = 4'd0;

  // x1 in the low half, y1 in the high half
  localparam logic [wb_addr_bits-1:0] reg_p1 = 4'd1;

  localparam logic [wb_addr_bits-1:0] reg_color = 4'd2;

  // any write here queues the staged line
  localparam logic [wb_addr_bits-1:0] reg_go = 4'd3;

  // lines done count below the idle bit
  localparam logic [wb_addr_bits-1:0] reg_status = 4'd4;

  // status bit positions
  localparam int status_idle_bit = 16;

endpackage

//--- verilog/gfx_fifo.sv
`timescale 1ns/1ps

module gfx_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);
  localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_bits = $clog2(depth + 1);

  payload_t              mem [depth];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [count_bits-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // pointers wrap at depth, which need not be a power of two
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == count_bits'(depth));
  assign empty   = (count == '0);

  // first word falls through to the head
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- verilog/gfx_cmd_regs.sv
`timescale 1ns/1ps

module gfx_cmd_regs
  import gfx_mode_pkg::*;
  import gfx_bus_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [wb_addr_bits-1:0] wb_adr,
  input  logic [wb_data_bits-1:0] wb_dat_w,
  output logic                    wb_ack,
  output logic [wb_data_bits-1:0] wb_dat_r,
  output logic                    cmd_push,
  output line_cmd_t               cmd_data,
  input  logic                    cmd_full,
  input  logic                    cmd_empty,
  input  logic                    line_done,
  input  logic                    raster_busy,
  input  logic                    pix_empty,
  input  logic                    writer_busy
);
  localparam int half = wb_data_bits / 2;

  // staged line, pushed as a whole on go
  logic [fb_x_bits-1:0]       x0_q;
  logic [fb_y_bits-1:0]       y0_q;
  logic [fb_x_bits-1:0]       x1_q;
  logic [fb_y_bits-1:0]       y1_q;
  logic [color_bits-1:0]      color_q;

  logic [status_idle_bit-1:0] lines_done;
  logic                       idle;
  logic                       req;
  logic                       go_req;
  logic                       accept;
  logic [wb_data_bits-1:0]    rd_word;

  // a request is new until its ack has been given
  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign go_req = req && wb_we && (wb_adr == reg_go);

  // go holds off its ack while the queue is full
  assign accept   = req && !(go_req && cmd_full);
  assign cmd_push = go_req && !cmd_full;
  assign cmd_data = '{x0: x0_q, y0: y0_q, x1: x1_q, y1: y1_q, color: color_q};

  // nothing queued, nothing drawing, nothing waiting for memory
  assign idle = cmd_empty && !raster_busy && pix_empty && !writer_busy;

  always_comb begin
    rd_word = '0;
    case (wb_adr)
      reg_p0: begin
        rd_word[fb_x_bits-1:0]      = x0_q;
        rd_word[half +: fb_y_bits]  = y0_q;
      end
      reg_p1: begin
        rd_word[fb_x_bits-1:0]      = x1_q;
        rd_word[half +: fb_y_bits]  = y1_q;
      end
      reg_color: rd_word[color_bits-1:0] = color_q;
      reg_status: begin
        rd_word[status_idle_bit-1:0] = lines_done;
        rd_word[status_idle_bit]     = idle;
      end
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack     <= 1'b0;
      lines_done <= '0;
    end else begin
      wb_ack <= accept;
      if (line_done) begin
        lines_done <= lines_done + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && wb_we) begin
      case (wb_adr)
        reg_p0: begin
          x0_q <= wb_dat_w[fb_x_bits-1:0];
          y0_q <= wb_dat_w[half +: fb_y_bits];
        end
        reg_p1: begin
          x1_q <= wb_dat_w[fb_x_bits-1:0];
          y1_q <= wb_dat_w[half +: fb_y_bits];
        end
        reg_color: color_q <= wb_dat_w[color_bits-1:0];
        default: ;
      endcase
    end
    if (accept && !wb_we) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

//--- verilog/gfx_line.sv
`timescale 1ns/1ps

module gfx_line
  import gfx_mode_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      cmd_empty,
  output logic      cmd_pop,
  input  line_cmd_t cmd_data,
  output logic      pix_push,
  output pixel_t    pix_data,
  input  logic      pix_full,
  output logic      busy,
  output logic      done
);
  localparam int cord_bits = (fb_x_bits > fb_y_bits) ? fb_x_bits : fb_y_bits;
  // room for the sign and for doubling the error
  localparam int err_bits  = cord_bits + 2;

  typedef enum logic [1:0] {
    st_idle,
    st_setup0,
    st_setup1,
    st_draw
  } state_t;

  state_t                      state;

  logic [fb_x_bits-1:0]        x;
  logic [fb_y_bits-1:0]        y;
  logic [fb_x_bits-1:0]        x_end;
  logic [fb_y_bits-1:0]        y_end;
  logic [color_bits-1:0]       color_q;
  logic                        left_to_right;

  // dx is positive, dy is zero or negative
  logic signed [err_bits-1:0]  dx;
  logic signed [err_bits-1:0]  dy;
  logic signed [err_bits-1:0]  err;

  logic                        at_x_end;
  logic                        at_y_end;
  logic                        movx;

  assign cmd_pop  = (state == st_idle) && !cmd_empty;
  assign pix_push = (state == st_draw) && !pix_full;
  assign pix_data = '{x: x, y: y, color: color_q};
  assign busy     = (state != st_idle);

  assign at_x_end = (x == x_end);
  assign at_y_end = (y == y_end);

  // one axis per step; once an axis is done only the other may move
  always_comb begin
    if (at_x_end) begin
      movx = 1'b0;
    end else if (at_y_end) begin
      movx = 1'b1;
    end else begin
      movx = ((err <<< 1) >= dy);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (!cmd_empty) begin
            state <= st_setup0;
          end
        end
        st_setup0: state <= st_setup1;
        st_setup1: state <= st_draw;
        st_draw: begin
          if (!pix_full && at_x_end && at_y_end) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        // start from the upper endpoint so y only grows
        if (cmd_data.y0 > cmd_data.y1) begin
          x     <= cmd_data.x1;
          y     <= cmd_data.y1;
          x_end <= cmd_data.x0;
          y_end <= cmd_data.y0;
        end else begin
          x     <= cmd_data.x0;
          y     <= cmd_data.y0;
          x_end <= cmd_data.x1;
          y_end <= cmd_data.y1;
        end
        color_q <= cmd_data.color;
      end
      st_setup0: begin
        left_to_right <= (x < x_end);
        dx <= (x < x_end) ? signed'({{(err_bits - fb_x_bits){1'b0}}, x_end - x})
                          : signed'({{(err_bits - fb_x_bits){1'b0}}, x - x_end});
        dy <= signed'({{(err_bits - fb_y_bits){1'b0}}, y})
            - signed'({{(err_bits - fb_y_bits){1'b0}}, y_end});
      end
      st_setup1: err <= dx + dy;
      st_draw: begin
        if (!pix_full && !(at_x_end && at_y_end)) begin
          if (movx) begin
            x   <= left_to_right ? x + 1'b1 : x - 1'b1;
            err <= err + dy;
          end else begin
            y   <= y + 1'b1;
            err <= err + dx;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/gfx_pixel_writer.sv
`timescale 1ns/1ps

module gfx_pixel_writer
  import gfx_mode_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pix_empty,
  output logic                    pix_pop,
  input  pixel_t                  pix_data,
  output logic                    busy,
  output logic                    fb_cyc,
  output logic                    fb_stb,
  output logic                    fb_we,
  output logic [fb_addr_bits-1:0] fb_adr,
  output logic [color_bits-1:0]   fb_dat,
  input  logic                    fb_ack
);
  localparam logic [fb_addr_bits-1:0] row_words = fb_addr_bits'(fb_width);

  // a write cycle is open from pop until ack
  logic                    active;
  logic [fb_addr_bits-1:0] pixel_addr;

  assign pixel_addr = fb_addr_bits'(pix_data.y) * row_words + fb_addr_bits'(pix_data.x);

  // take the next pixel only between cycles
  assign pix_pop = !active && !pix_empty;

  assign fb_cyc = active;
  assign fb_stb = active;
  // write only port
  assign fb_we  = active;
  assign busy   = active;

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (active) begin
      if (fb_ack) begin
        active <= 1'b0;
      end
    end else if (!pix_empty) begin
      active <= 1'b1;
    end
  end

  // address and data held until ack
  always_ff @(posedge clk) begin
    if (pix_pop) begin
      fb_adr <= pixel_addr;
      fb_dat <= pix_data.color;
    end
  end

endmodule

//--- verilog/gfx_line_engine.sv
`timescale 1ns/1ps

module gfx_line_engine
  import gfx_mode_pkg::*;
  import gfx_bus_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [wb_addr_bits-1:0] wb_adr,
  input  logic [wb_data_bits-1:0] wb_dat_w,
  output logic                    wb_ack,
  output logic [wb_data_bits-1:0] wb_dat_r,
  output logic                    fb_cyc,
  output logic                    fb_stb,
  output logic                    fb_we,
  output logic [fb_addr_bits-1:0] fb_adr,
  output logic [color_bits-1:0]   fb_dat,
  input  logic                    fb_ack
);
  // host side of the command queue
  logic      cmd_push;
  line_cmd_t cmd_in;
  logic      cmd_full;
  // rasterizer side of the command queue
  logic      cmd_pop;
  line_cmd_t cmd_head;
  logic      cmd_empty;

  logic      pix_push;
  pixel_t    pix_in;
  logic      pix_full;
  logic      pix_pop;
  pixel_t    pix_head;
  logic      pix_empty;

  logic      line_done;
  logic      raster_busy;
  logic      writer_busy;

  gfx_cmd_regs u_cmd_regs (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
    .cmd_push(cmd_push), .cmd_data(cmd_in), .cmd_full(cmd_full), .cmd_empty(cmd_empty),
    .line_done(line_done), .raster_busy(raster_busy),
    .pix_empty(pix_empty), .writer_busy(writer_busy)
  );

  gfx_fifo #(.payload_t(line_cmd_t), .depth(cmd_fifo_depth)) u_cmd_fifo (
    .clk(clk), .reset(reset),
    .push(cmd_push), .push_data(cmd_in), .full(cmd_full),
    .pop(cmd_pop), .pop_data(cmd_head), .empty(cmd_empty)
  );

  gfx_line u_line (
    .clk(clk), .reset(reset),
    .cmd_empty(cmd_empty), .cmd_pop(cmd_pop), .cmd_data(cmd_head),
    .pix_push(pix_push), .pix_data(pix_in), .pix_full(pix_full),
    .busy(raster_busy), .done(line_done)
  );

  gfx_fifo #(.payload_t(pixel_t), .depth(pix_fifo_depth)) u_pix_fifo (
    .clk(clk), .reset(reset),
    .push(pix_push), .push_data(pix_in), .full(pix_full),
    .pop(pix_pop), .pop_data(pix_head), .empty(pix_empty)
  );

  gfx_pixel_writer u_pixel_writer (
    .clk(clk), .reset(reset),
    .pix_empty(pix_empty), .pix_pop(pix_pop), .pix_data(pix_head), .busy(writer_busy),
    .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we),
    .fb_adr(fb_adr), .fb_dat(fb_dat), .fb_ack(fb_ack)
  );

endmodule

//--- tests/gfx_line_engine_properties.sv
`timescale 1ns/1ps

module gfx_line_engine_properties
  import gfx_mode_pkg::*;
(
  input logic                    clk,
  input logic                    reset,
  input logic                    wb_ack,
  input logic                    fb_cyc,
  input logic                    fb_stb,
  input logic                    fb_ack,
  input logic [fb_addr_bits-1:0] fb_adr,
  input logic [color_bits-1:0]   fb_dat
);
  // number of failed properties, read by the testbench at the end
  int unsigned violations = 0;

  stb_inside_cyc: assert property (@(posedge clk) disable iff (reset) fb_stb |-> fb_cyc)
    else begin
      violations++;
      $error("fb_stb is high while fb_cyc is low");
    end

  // a waiting request keeps its address and data
  request_held: assert property (@(posedge clk) disable iff (reset)
    (fb_stb && !fb_ack) |=> ($stable(fb_adr) && $stable(fb_dat)))
    else begin
      violations++;
      $error("fb_adr or fb_dat changed before fb_ack");
    end

  adr_in_range: assert property (@(posedge clk) disable iff (reset)
    fb_cyc |-> (fb_adr < fb_addr_bits'(fb_width * fb_height)))
    else begin
      violations++;
      $error("fb_adr points outside the framebuffer");
    end

  ack_single_pulse: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
      violations++;
      $error("wb_ack stayed high for two cycles");
    end

endmodule

//--- tests/gfx_line_engine_tb.sv
`timescale 1ns/1ps

module gfx_line_engine_tb
  import gfx_mode_pkg::*;
  import gfx_bus_pkg::*;
();
  localparam int clk_ns          = 100;
  localparam int drive_delay     = 1;
  localparam int reset_cycles    = 16;
  localparam int half            = wb_data_bits / 2;
  // 3 axis lines, 4 diagonal lines, 6 queued back to back
  localparam int num_lines       = 13;
  localparam int max_pixels      = 110;
  localparam int watchdog_cycles = num_lines * 4 * (max_pixels + 8) + 2000;

  logic                    clk;
  logic                    reset;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [wb_addr_bits-1:0] wb_adr;
  logic [wb_data_bits-1:0] wb_dat_w;
  logic                    wb_ack;
  logic [wb_data_bits-1:0] wb_dat_r;
  logic                    fb_cyc;
  logic                    fb_stb;
  logic                    fb_we;
  logic [fb_addr_bits-1:0] fb_adr;
  logic [color_bits-1:0]   fb_dat;
  logic                    fb_ack;

  logic [color_bits-1:0]   fb_mem [fb_width * fb_height];
  // every framebuffer write in bus order
  int                      log_adr[$];
  int                      log_dat[$];
  int                      log_pos = 0;
  line_cmd_t               exp_lines[$];
  int                      lines_checked = 0;
  int                      ack_wait = -1;
  int                      max_ack_wait = 0;
  int                      value_errors = 0;
  int                      other_errors = 0;
  int                      total_pixels;
  logic [wb_data_bits-1:0] rdata;

  gfx_line_engine u_gfx_line_engine (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
    .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we),
    .fb_adr(fb_adr), .fb_dat(fb_dat), .fb_ack(fb_ack)
  );

  bind gfx_line_engine gfx_line_engine_properties u_properties (
    .clk(clk), .reset(reset), .wb_ack(wb_ack), .fb_cyc(fb_cyc), .fb_stb(fb_stb),
    .fb_ack(fb_ack), .fb_adr(fb_adr), .fb_dat(fb_dat)
  );

  function automatic int abs_diff(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  task automatic check_value(input string test, input int expected, input int actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("error %s: expected %0d, got %0d", test, expected, actual);
    end
  endtask

  task automatic check_true(input string test, input bit ok, input string what);
    assert (ok) else begin
      other_errors++;
      $display("error %s: %s", test, what);
    end
  endtask

  // one Wishbone classic cycle, held until ack
  task automatic host_cycle(input bit we, input logic [wb_addr_bits-1:0] adr,
                            input logic [wb_data_bits-1:0] wdat,
                            output logic [wb_data_bits-1:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    #drive_delay;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(posedge clk);
      #drive_delay;
      waited++;
    end while (!wb_ack);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (we && waited > max_ack_wait) begin
      max_ack_wait = waited;
    end
  endtask

  task automatic host_write(input logic [wb_addr_bits-1:0] adr, input int dat);
    logic [wb_data_bits-1:0] ignored;
    host_cycle(1'b1, adr, dat, ignored);
  endtask

  task automatic host_read(input logic [wb_addr_bits-1:0] adr,
                           output logic [wb_data_bits-1:0] dat);
    host_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic queue_line(input int x0, input int y0, input int x1, input int y1,
                            input int color);
    host_write(reg_p0, (y0 << half) | x0);
    host_write(reg_p1, (y1 << half) | x1);
    host_write(reg_color, color);
    host_write(reg_go, 1);
    exp_lines.push_back('{x0: x0, y0: y0, x1: x1, y1: y1, color: color});
  endtask

  // poll status until idle, then the count must match every go so far
  task automatic wait_idle(input string test);
    logic [wb_data_bits-1:0] status;
    status = '0;
    while (!status[status_idle_bit]) begin
      host_read(reg_status, status);
    end
    check_value({test, " status"}, (1 << status_idle_bit) | exp_lines.size(), status);
  endtask

  // walks the next writes of the log as one line drawn from its upper endpoint
  task automatic check_line(input string test, input line_cmd_t cmd, input bit last);
    int n, xs, ys, xe, ye, x, y, px, py, a;
    n  = abs_diff(cmd.x0, cmd.x1) + abs_diff(cmd.y0, cmd.y1) + 1;
    xs = (cmd.y0 > cmd.y1) ? cmd.x1 : cmd.x0;
    ys = (cmd.y0 > cmd.y1) ? cmd.y1 : cmd.y0;
    xe = (cmd.y0 > cmd.y1) ? cmd.x0 : cmd.x1;
    ye = (cmd.y0 > cmd.y1) ? cmd.y0 : cmd.y1;
    px = xs;
    py = ys;
    check_true(test, log_adr.size() >= log_pos + n, "fewer framebuffer writes than pixels");
    if (log_adr.size() < log_pos + n) begin
      return;
    end
    // a flat line may run either way
    if (ys == ye && log_adr[log_pos] % fb_width == xe) begin
      a  = xs;
      xs = xe;
      xe = a;
    end
    for (int k = 0; k < n; k++) begin
      a = log_adr[log_pos + k];
      x = a % fb_width;
      y = a / fb_width;
      check_value({test, " color"}, cmd.color, log_dat[log_pos + k]);
      check_value({test, " steps from start"}, k, abs_diff(x, xs) + abs_diff(y, ys));
      check_value({test, " steps to end"}, n - 1 - k, abs_diff(x, xe) + abs_diff(y, ye));
      check_true(test, abs_diff(x, xs) + abs_diff(x, xe) == abs_diff(xs, xe) &&
                 abs_diff(y, ys) + abs_diff(y, ye) == abs_diff(ys, ye),
                 "pixel outside the bounding box");
      if (k > 0) begin
        check_value({test, " step length"}, 1, abs_diff(x, px) + abs_diff(y, py));
        check_true(test, y >= py, "y coordinate moved upward");
      end
      if (last) begin
        check_value({test, " memory word"}, cmd.color, fb_mem[a]);
      end
      px = x;
      py = y;
    end
    log_pos += n;
  endtask

  task automatic check_new_lines(input string test);
    while (lines_checked < exp_lines.size()) begin
      check_line(test, exp_lines[lines_checked], lines_checked == exp_lines.size() - 1);
      lines_checked++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2) clk = ~clk;
  end

  // framebuffer memory, acks each request after 0 to 3 cycles
  initial begin
    void'($urandom(60551));
    fb_ack = 1'b0;
    forever begin
      @(posedge clk);
      #drive_delay;
      if (fb_ack) begin
        fb_ack = 1'b0;
      end else if (fb_cyc && fb_stb) begin
        if (ack_wait < 0) begin
          ack_wait = $urandom_range(3);
        end
        if (ack_wait == 0) begin
          check_true("framebuffer bus", fb_we, "write cycle with fb_we low");
          if (fb_adr < fb_width * fb_height) begin
            fb_mem[fb_adr] = fb_dat;
          end
          log_adr.push_back(fb_adr);
          log_dat.push_back(fb_dat);
          fb_ack   = 1'b1;
          ack_wait = -1;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the line engine did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;

    host_read(reg_status, rdata);
    check_value("registers status after reset", 1 << status_idle_bit, rdata);
    host_write(reg_p0, (77 << half) | 301);
    host_write(reg_p1, (199 << half) | 12);
    host_write(reg_color, 'ha5);
    host_read(reg_p0, rdata);
    check_value("registers p0", (77 << half) | 301, rdata);
    host_read(reg_p1, rdata);
    check_value("registers p1", (199 << half) | 12, rdata);
    host_read(reg_color, rdata);
    check_value("registers color", 'ha5, rdata);
    host_read(4'd9, rdata);
    check_value("registers unmapped", 0, rdata);

    queue_line(10, 20, 90, 20, 'h11);
    queue_line(200, 100, 200, 30, 'h22);
    queue_line(5, 5, 5, 5, 'h33);
    wait_idle("axis lines");
    check_new_lines("axis lines");

    // endpoints given bottom first
    queue_line(40, 200, 90, 180, 'h51);
    queue_line(140, 200, 90, 170, 'h52);
    queue_line(250, 230, 260, 160, 'h53);
    queue_line(300, 230, 280, 150, 'h54);
    wait_idle("diagonal lines");
    check_new_lines("diagonal lines");

    max_ack_wait = 0;
    for (int i = 0; i < 6; i++) begin
      queue_line(10 + 45 * i, 60 + 10 * i, 60 + 25 * i, 20 + 15 * i, 'h41 + i);
    end
    check_true("back-pressure", max_ack_wait > 1, "go ack never stalled on a full queue");
    wait_idle("back-pressure");
    check_new_lines("back-pressure");

    wait_idle("completion");
    total_pixels = 0;
    foreach (exp_lines[i]) begin
      total_pixels += abs_diff(exp_lines[i].x0, exp_lines[i].x1) +
                      abs_diff(exp_lines[i].y0, exp_lines[i].y1) + 1;
    end
    check_value("completion total writes", total_pixels, log_adr.size());
    check_value("bus properties", 0, u_gfx_line_engine.u_properties.violations);

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
verilog/gfx_mode_pkg.sv
verilog/gfx_bus_pkg.sv
verilog/gfx_fifo.sv
verilog/gfx_cmd_regs.sv
verilog/gfx_line.sv
verilog/gfx_pixel_writer.sv
verilog/gfx_line_engine.sv
tests/gfx_line_engine_properties.sv
tests/gfx_line_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the line engine testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module gfx_line_engine_tb -o gfx_line_engine_sim \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/gfx_line_engine_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }
